// ==== xv_pkg.sv ====
// all words 16 bits; register numbers 11..15 are unused and read back as 0
package xv_pkg;

typedef logic [15:0] word_t;        // vram word, register value, palette entry
typedef logic [15:0] vaddr_t;       // vram word address
typedef logic [3:0]  nibble_mask_t; // bit n enables nibble n
typedef logic [7:0]  color_idx_t;   // palette index
typedef logic [3:0]  intr_t;        // bit 0 vsync, bits 3..1 host raised

// palette entry bits 11..0
typedef struct packed {
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
} rgb_t;

typedef enum logic [3:0] {
    R_STATUS      = 4'h0,   // [15] busy, [3:0] intr status
    R_INTR_MASK   = 4'h1,
    R_INTR_CLEAR  = 4'h2,   // 1s clear status bits
    R_INTR_SIGNAL = 4'h3,   // 1s raise sources
    R_WR_ADDR     = 4'h4,
    R_WR_MASK     = 4'h5,
    R_DATA        = 4'h6,   // masked vram write then wr addr + 1
    R_RD_ADDR     = 4'h7,   // queues a vram read
    R_RD_DATA     = 4'h8,   // last read result
    R_PAL_ADDR    = 4'h9,
    R_PAL_DATA    = 4'hA    // palette write then pal addr + 1
} reg_num_e;

// host request toward vram
typedef struct packed {
    logic         wr;       // 1 write, 0 read
    vaddr_t       addr;
    word_t        data;
    nibble_mask_t mask;
} vram_req_t;

typedef struct packed {
    logic       en;
    color_idx_t addr;
    word_t      data;
} pal_wr_t;

typedef struct packed {
    logic hsync;
    logic vsync;
    logic de;               // display enable
} vid_sync_t;

typedef enum logic [1:0] {
    IDLE,                   // no fetch
    FETCH,                  // vram select this cycle
    HOLD                    // fetched word on the data bus
} vid_state_e;

endpackage

// ==== bus_regs.sv ====
// one vram access in flight; host polls busy first or a new R_DATA / R_RD_ADDR write is dropped
`default_nettype none
`timescale 1ns/1ns

module bus_regs import xv_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire logic       bus_cs_n_i,         // strobe, active low
    input  wire logic       bus_rd_nwr_i,       // 1 read, 0 write
    input  wire reg_num_e   bus_reg_num_i,
    input  wire logic       bus_bytesel_i,      // 0 upper byte, 1 lower byte
    input  wire logic [7:0] bus_data_i,
    output logic      [7:0] bus_data_o,
    output vram_req_t       vram_req_o,
    output logic            vram_req_valid_o,
    input  wire logic       vram_ready_i,
    input  wire word_t      vram_rd_data_i,
    input  wire logic       vram_rd_done_i,
    output pal_wr_t         pal_wr_o,
    output intr_t           intr_mask_o,
    output intr_t           intr_clear_o,
    output intr_t           intr_signal_o,
    input  wire intr_t      intr_status_i
);

logic [7:0]   hi_byte;          // even byte waiting for its partner
word_t        wr_word;
logic         wr_commit;        // odd byte write
logic         rd_strobe;
logic         busy;
logic         rd_pending;       // read transferred, data not back yet
vaddr_t       wr_addr;
nibble_mask_t wr_mask;
word_t        rd_data;
color_idx_t   pal_addr;
word_t        reg_word;         // register picked for read-back

assign wr_word   = {hi_byte, bus_data_i};
assign wr_commit = !bus_cs_n_i && !bus_rd_nwr_i && bus_bytesel_i;
assign rd_strobe = !bus_cs_n_i && bus_rd_nwr_i;

always_ff @(posedge clk) begin
    if (!bus_cs_n_i && !bus_rd_nwr_i && !bus_bytesel_i) begin
        hi_byte <= bus_data_i;
    end
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        busy             <= 1'b0;
        rd_pending       <= 1'b0;
        vram_req_valid_o <= 1'b0;
        wr_addr          <= '0;
        wr_mask          <= 4'hF;       // all nibbles
        pal_addr         <= '0;
        pal_wr_o         <= '0;
        intr_mask_o      <= '0;
        intr_clear_o     <= '0;
        intr_signal_o    <= '0;
    end else begin
        intr_clear_o  <= '0;            // strobes last one cycle
        intr_signal_o <= '0;
        pal_wr_o.en   <= 1'b0;
        if (vram_req_valid_o && vram_ready_i) begin
            vram_req_valid_o <= 1'b0;
            rd_pending       <= !vram_req_o.wr;
            busy             <= !vram_req_o.wr;  // writes done at transfer
        end
        if (rd_pending && vram_rd_done_i) begin
            rd_data    <= vram_rd_data_i;
            rd_pending <= 1'b0;
            busy       <= 1'b0;
        end
        if (wr_commit) begin
            case (bus_reg_num_i)
                R_INTR_MASK:   intr_mask_o   <= wr_word[3:0];
                R_INTR_CLEAR:  intr_clear_o  <= wr_word[3:0];
                R_INTR_SIGNAL: intr_signal_o <= wr_word[3:0];
                R_WR_ADDR:     wr_addr       <= wr_word;
                R_WR_MASK:     wr_mask       <= wr_word[3:0];
                R_PAL_ADDR:    pal_addr      <= wr_word[7:0];
                R_DATA: begin
                    if (!busy) begin
                        vram_req_o       <= '{wr: 1'b1, addr: wr_addr,
                                              data: wr_word, mask: wr_mask};
                        vram_req_valid_o <= 1'b1;
                        busy             <= 1'b1;
                        wr_addr          <= wr_addr + 1'b1;
                    end
                end
                R_RD_ADDR: begin
                    if (!busy) begin
                        vram_req_o       <= '{wr: 1'b0, addr: wr_word,
                                              data: '0, mask: '0};
                        vram_req_valid_o <= 1'b1;
                        busy             <= 1'b1;
                    end
                end
                R_PAL_DATA: begin
                    pal_wr_o <= '{en: 1'b1, addr: pal_addr, data: wr_word};
                    pal_addr <= pal_addr + 1'b1;
                end
                default: ;
            endcase
        end
    end
end

// read-back mux
always_comb begin
    case (bus_reg_num_i)
        R_STATUS:    reg_word = {busy, 11'b0, intr_status_i};
        R_INTR_MASK: reg_word = {12'b0, intr_mask_o};
        R_WR_ADDR:   reg_word = wr_addr;
        R_WR_MASK:   reg_word = {12'b0, wr_mask};
        R_RD_DATA:   reg_word = rd_data;
        R_PAL_ADDR:  reg_word = {8'b0, pal_addr};
        default:     reg_word = '0;      // write only or unused
    endcase
end

always_ff @(posedge clk) begin
    if (rd_strobe) begin
        bus_data_o <= bus_bytesel_i ? reg_word[7:0] : reg_word[15:8];
    end
end

endmodule
`default_nettype wire

// ==== vram_port.sv ====
// single port vram; video fetch always wins and the host waits on ready; depth a power of two
`default_nettype none
`timescale 1ns/1ns

module vram_port import xv_pkg::*; #(
    parameter int VRAM_WORDS = 4096
) (
    input  wire logic      clk,
    input  wire logic      vid_sel_i,       // video owns the port
    input  wire vaddr_t    vid_addr_i,
    output word_t          vid_data_o,      // valid cycle after vid_sel_i
    input  wire vram_req_t req_i,
    input  wire logic      req_valid_i,
    output logic           req_ready_o,
    output word_t          rd_data_o,
    output logic           rd_done_o        // rd_data_o is a host read
);

localparam int AW = $clog2(VRAM_WORDS);

word_t         mem [VRAM_WORDS];
word_t         rd_word;         // shared read register
logic [AW-1:0] port_addr;
logic          host_go;         // host request transfers
logic          port_we;

assign req_ready_o = !vid_sel_i;
assign host_go     = req_valid_i && req_ready_o;
assign port_we     = host_go && req_i.wr;
assign port_addr   = vid_sel_i ? vid_addr_i[AW-1:0] : req_i.addr[AW-1:0];

always_ff @(posedge clk) begin
    if (port_we) begin
        for (int n = 0; n < 4; n++) begin
            if (req_i.mask[n]) begin
                mem[port_addr][n*4 +: 4] <= req_i.data[n*4 +: 4];  // masked nibble
            end
        end
    end else if (vid_sel_i || host_go) begin
        rd_word <= mem[port_addr];
    end
    rd_done_o <= host_go && !req_i.wr;     // tag for the host
end

assign vid_data_o = rd_word;
assign rd_data_o  = rd_word;

endmodule
`default_nettype wire

// ==== video_gen.sv ====
// syncs active high, H_VISIBLE even; index and syncs lag the counters by 3 cycles
`default_nettype none
`timescale 1ns/1ns

module video_gen import xv_pkg::*; #(
    parameter int H_VISIBLE = 640,
    parameter int H_FRONT   = 16,
    parameter int H_SYNC    = 96,
    parameter int H_BACK    = 48,
    parameter int V_VISIBLE = 480,
    parameter int V_FRONT   = 10,
    parameter int V_SYNC    = 2,
    parameter int V_BACK    = 33
) (
    input  wire logic  clk,
    input  wire logic  reset_i,
    output logic       vid_sel_o,
    output vaddr_t     vid_addr_o,
    input  wire word_t vid_data_i,
    output color_idx_t color_idx_o,
    output vid_sync_t  sync_o,
    output logic       vsync_intr_o     // first vsync cycle on sync_o
);

localparam int H_TOTAL = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
localparam int V_TOTAL = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;
localparam int HW      = $clog2(H_TOTAL);
localparam int VW      = $clog2(V_TOTAL);

localparam logic [HW-1:0] HS_ON  = HW'(H_VISIBLE + H_FRONT);
localparam logic [HW-1:0] HS_OFF = HW'(H_VISIBLE + H_FRONT + H_SYNC);
localparam logic [VW-1:0] VS_ON  = VW'(V_VISIBLE + V_FRONT);
localparam logic [VW-1:0] VS_OFF = VW'(V_VISIBLE + V_FRONT + V_SYNC);

logic [HW-1:0] h_count;
logic [VW-1:0] v_count;
logic          h_last;
logic          visible;
vaddr_t        line_addr;       // word at x = 0 of this line
vid_state_e    state;
vid_state_e    state_next;
vid_sync_t     sync_now;        // straight from counters
vid_sync_t     sync_d1;
vid_sync_t     sync_d2;
color_idx_t    lo_byte;         // odd pixel of fetched word

assign h_last  = h_count == HW'(H_TOTAL - 1);
assign visible = (h_count < HW'(H_VISIBLE)) && (v_count < VW'(V_VISIBLE));

assign sync_now.hsync = (h_count >= HS_ON) && (h_count < HS_OFF);
assign sync_now.vsync = (v_count >= VS_ON) && (v_count < VS_OFF);
assign sync_now.de    = visible;

// fetch on even visible pixel, data back next cycle
always_comb begin
    if (visible && !h_count[0]) begin
        state_next = FETCH;
    end else if (state == FETCH) begin
        state_next = HOLD;
    end else begin
        state_next = IDLE;
    end
end

assign vid_sel_o = state == FETCH;

always_ff @(posedge clk) begin
    if (reset_i) begin
        h_count      <= '0;
        v_count      <= '0;
        line_addr    <= '0;
        state        <= IDLE;
        sync_d1      <= '0;
        sync_d2      <= '0;
        sync_o       <= '0;
        color_idx_o  <= '0;
        vsync_intr_o <= 1'b0;
    end else begin
        state   <= state_next;
        h_count <= h_last ? '0 : h_count + 1'b1;
        if (h_last) begin
            if (v_count == VW'(V_TOTAL - 1)) begin
                v_count   <= '0;
                line_addr <= '0;            // new frame
            end else begin
                v_count <= v_count + 1'b1;
                if (v_count < VW'(V_VISIBLE)) begin
                    line_addr <= line_addr + vaddr_t'(H_VISIBLE / 2);
                end
            end
        end
        sync_d1      <= sync_now;
        sync_d2      <= sync_d1;
        sync_o       <= sync_d2;
        vsync_intr_o <= sync_d2.vsync && !sync_o.vsync;
        color_idx_o  <= (state == HOLD) ? vid_data_i[15:8] : lo_byte;  // upper byte first
    end
end

// fetch address and odd pixel byte
always_ff @(posedge clk) begin
    vid_addr_o <= line_addr + vaddr_t'(h_count >> 1);
    if (state == HOLD) begin
        lo_byte <= vid_data_i[7:0];
    end
end

endmodule
`default_nettype wire

// ==== palette_out.sv ====
// palette read is combinational so color and syncs lag the input by one cycle; bits 15..12 unused
`default_nettype none
`timescale 1ns/1ns

module palette_out import xv_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire pal_wr_t    pal_wr_i,
    input  wire color_idx_t color_idx_i,
    input  wire vid_sync_t  sync_i,
    output rgb_t            rgb_o,
    output vid_sync_t       sync_o
);

word_t pal_mem [256];
word_t pal_entry;               // lookup for this pixel

assign pal_entry = pal_mem[color_idx_i];

always_ff @(posedge clk) begin
    if (pal_wr_i.en) begin
        pal_mem[pal_wr_i.addr] <= pal_wr_i.data;
    end
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        rgb_o  <= '0;
        sync_o <= '0;
    end else begin
        sync_o <= sync_i;
        rgb_o  <= sync_i.de ? rgb_t'(pal_entry[11:0]) : '0;  // black in blanking
    end
end

endmodule
`default_nettype wire

// ==== intr_ctrl.sv ====
// source 0 is the vsync strobe; a clear wins over a raise of the same bit in one cycle
`default_nettype none
`timescale 1ns/1ns

module intr_ctrl import xv_pkg::*; (
    input  wire logic  clk,
    input  wire logic  reset_i,
    input  wire intr_t mask_i,          // 1 enables a source
    input  wire intr_t clear_i,
    input  wire intr_t signal_i,
    input  wire logic  vsync_intr_i,
    output intr_t      status_o,
    output logic       bus_intr_o
);

intr_t raised;

assign raised = signal_i | {3'b000, vsync_intr_i};

always_ff @(posedge clk) begin
    if (reset_i) begin
        status_o   <= '0;
        bus_intr_o <= 1'b0;
    end else begin
        bus_intr_o <= |(raised & mask_i & ~status_o);  // new enabled source only
        status_o   <= (status_o | raised) & ~clear_i;
    end
end

endmodule
`default_nettype wire

// ==== xosera_top.sv ====
// video outputs trail video_gen by one palette cycle; host vram latency varies, watch busy
`default_nettype none
`timescale 1ns/1ns

module xosera_top import xv_pkg::*; #(
    parameter int H_VISIBLE  = 640,
    parameter int H_FRONT    = 16,
    parameter int H_SYNC     = 96,
    parameter int H_BACK     = 48,
    parameter int V_VISIBLE  = 480,
    parameter int V_FRONT    = 10,
    parameter int V_SYNC     = 2,
    parameter int V_BACK     = 33,
    parameter int VRAM_WORDS = 4096
) (
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire logic       bus_cs_n_i,     // strobe, active low
    input  wire logic       bus_rd_nwr_i,
    input  wire reg_num_e   bus_reg_num_i,
    input  wire logic       bus_bytesel_i,
    input  wire logic [7:0] bus_data_i,
    output logic      [7:0] bus_data_o,
    output logic            bus_intr_o,
    output logic      [3:0] red_o,
    output logic      [3:0] green_o,
    output logic      [3:0] blue_o,
    output logic            hsync_o,
    output logic            vsync_o,
    output logic            dv_de_o
);

vram_req_t  vram_req;           // host to vram
logic       vram_req_valid;
logic       vram_ready;
word_t      vram_rd_data;
logic       vram_rd_done;
pal_wr_t    pal_wr;
intr_t      intr_mask;
intr_t      intr_clear;
intr_t      intr_signal;
intr_t      intr_status;
logic       vid_sel;            // video fetch
vaddr_t     vid_addr;
word_t      vid_data;
color_idx_t color_idx;
vid_sync_t  vid_sync;           // before palette
vid_sync_t  out_sync;           // after palette
rgb_t       rgb;
logic       vsync_intr;

assign red_o   = rgb.red;
assign green_o = rgb.green;
assign blue_o  = rgb.blue;
assign hsync_o = out_sync.hsync;
assign vsync_o = out_sync.vsync;
assign dv_de_o = out_sync.de;

bus_regs u_bus_regs (
    .clk              (clk),
    .reset_i          (reset_i),
    .bus_cs_n_i       (bus_cs_n_i),
    .bus_rd_nwr_i     (bus_rd_nwr_i),
    .bus_reg_num_i    (bus_reg_num_i),
    .bus_bytesel_i    (bus_bytesel_i),
    .bus_data_i       (bus_data_i),
    .bus_data_o       (bus_data_o),
    .vram_req_o       (vram_req),
    .vram_req_valid_o (vram_req_valid),
    .vram_ready_i     (vram_ready),
    .vram_rd_data_i   (vram_rd_data),
    .vram_rd_done_i   (vram_rd_done),
    .pal_wr_o         (pal_wr),
    .intr_mask_o      (intr_mask),
    .intr_clear_o     (intr_clear),
    .intr_signal_o    (intr_signal),
    .intr_status_i    (intr_status)
);

vram_port #(
    .VRAM_WORDS (VRAM_WORDS)
) u_vram_port (
    .clk         (clk),
    .vid_sel_i   (vid_sel),
    .vid_addr_i  (vid_addr),
    .vid_data_o  (vid_data),
    .req_i       (vram_req),
    .req_valid_i (vram_req_valid),
    .req_ready_o (vram_ready),
    .rd_data_o   (vram_rd_data),
    .rd_done_o   (vram_rd_done)
);

video_gen #(
    .H_VISIBLE (H_VISIBLE),
    .H_FRONT   (H_FRONT),
    .H_SYNC    (H_SYNC),
    .H_BACK    (H_BACK),
    .V_VISIBLE (V_VISIBLE),
    .V_FRONT   (V_FRONT),
    .V_SYNC    (V_SYNC),
    .V_BACK    (V_BACK)
) u_video_gen (
    .clk          (clk),
    .reset_i      (reset_i),
    .vid_sel_o    (vid_sel),
    .vid_addr_o   (vid_addr),
    .vid_data_i   (vid_data),
    .color_idx_o  (color_idx),
    .sync_o       (vid_sync),
    .vsync_intr_o (vsync_intr)
);

palette_out u_palette_out (
    .clk         (clk),
    .reset_i     (reset_i),
    .pal_wr_i    (pal_wr),
    .color_idx_i (color_idx),
    .sync_i      (vid_sync),
    .rgb_o       (rgb),
    .sync_o      (out_sync)
);

intr_ctrl u_intr_ctrl (
    .clk          (clk),
    .reset_i      (reset_i),
    .mask_i       (intr_mask),
    .clear_i      (intr_clear),
    .signal_i     (intr_signal),
    .vsync_intr_i (vsync_intr),
    .status_o     (intr_status),
    .bus_intr_o   (bus_intr_o)
);

endmodule
`default_nettype wire

// ==== tb_checks.svh ====
// bus tasks start on the next rising edge, drive 1 ns after it and return 1 ns after their last edge
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// even byte latched, odd byte commits the word
task automatic reg_write(input reg_num_e num, input word_t value);
    @(posedge clk);
    #1;
    cs_n    = 1'b0;
    rd_nwr  = 1'b0;
    reg_num = num;
    bytesel = 1'b0;
    din     = value[15:8];
    @(posedge clk);
    #1;
    bytesel = 1'b1;
    din     = value[7:0];
    @(posedge clk);
    #1;
    cs_n = 1'b1;                // commit edge just passed
endtask

// each byte comes back one cycle after its strobe
task automatic reg_read(input reg_num_e num, output word_t value);
    @(posedge clk);
    #1;
    cs_n    = 1'b0;
    rd_nwr  = 1'b1;
    reg_num = num;
    bytesel = 1'b0;
    @(posedge clk);
    #1;
    value[15:8] = dout;
    bytesel     = 1'b1;
    @(posedge clk);
    #1;
    value[7:0] = dout;
    cs_n       = 1'b1;
endtask

task automatic wait_not_busy();
    word_t st;
    st = 16'h8000;
    while (st[15]) begin
        reg_read(R_STATUS, st);    // busy in bit 15
    end
endtask

task automatic vram_read(input vaddr_t a, output word_t value);
    reg_write(R_RD_ADDR, a);
    wait_not_busy();
    reg_read(R_RD_DATA, value);
endtask

task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
        $display("[ERROR] %s got 0x%04h expected 0x%04h", name, got, exp);
        fail_run();
    end
endtask

task automatic check_rgb(input string name, input rgb_t got, input rgb_t exp);
    if (got !== exp) begin
        $display("[ERROR] %s got 0x%03h expected 0x%03h", name, got, exp);
        fail_run();
    end
endtask

task automatic check_intr(input string name, input intr_t got, input intr_t exp);
    if (got !== exp) begin
        $display("[ERROR] %s got 0x%01h expected 0x%01h", name, got, exp);
        fail_run();
    end
endtask

`endif

// ==== tb_xosera.sv ====
// small video timing so frames are short; vram words 0..127 hold test data, 0..63 form the image
`timescale 1ns/1ns

module tb_xosera import xv_pkg::*; ();

localparam int CLK_NS     = 4;
localparam int H_VIS      = 16;
localparam int H_FRONT    = 2;
localparam int H_SYNC     = 3;
localparam int H_BACK     = 3;
localparam int V_VIS      = 8;
localparam int V_FRONT    = 1;
localparam int V_SYNC     = 2;
localparam int V_BACK     = 1;
localparam int H_TOTAL    = H_VIS + H_FRONT + H_SYNC + H_BACK;
localparam int FRAME      = H_TOTAL * (V_VIS + V_FRONT + V_SYNC + V_BACK);  // cycles
localparam int VRAM_WORDS = 4096;
localparam int IMG_WORDS  = V_VIS * H_VIS / 2;     // words shown on screen
localparam int FILL_WORDS = 128;
localparam int N_MASKED   = 16;
localparam int N_LIVE     = 16;
localparam int N_INTR     = 12;
// register accesses of the whole run, roughly 3 cycles each plus busy polls
localparam int BUS_ACCESSES = 16 + 3 * FILL_WORDS + 6 * N_MASKED + 260 + 7 * N_LIVE
                              + 3 * N_INTR;
localparam int WATCH_CYCLES = 3 * FRAME + 4 * BUS_ACCESSES;

logic       clk = 1'b0;
logic       reset_i;
logic       cs_n;                   // host strobe, active low
logic       rd_nwr;
reg_num_e   reg_num;
logic       bytesel;
logic [7:0] din;
logic [7:0] dout;
logic       bus_intr;
logic [3:0] red;
logic [3:0] green;
logic [3:0] blue;
logic       hsync;
logic       vsync;
logic       de;

word_t        vram_model [VRAM_WORDS];
word_t        pal_model [256];
vaddr_t       wr_addr_model;
nibble_mask_t mask_model;
color_idx_t   pal_addr_model;
intr_t        imask_model;
intr_t        istat_model;     // host sources only, bit 0 follows vsync

always #(CLK_NS / 2) clk = ~clk;

xosera_top #(
    .H_VISIBLE  (H_VIS),
    .H_FRONT    (H_FRONT),
    .H_SYNC     (H_SYNC),
    .H_BACK     (H_BACK),
    .V_VISIBLE  (V_VIS),
    .V_FRONT    (V_FRONT),
    .V_SYNC     (V_SYNC),
    .V_BACK     (V_BACK),
    .VRAM_WORDS (VRAM_WORDS)
) u_xosera_top (
    .clk           (clk),
    .reset_i       (reset_i),
    .bus_cs_n_i    (cs_n),
    .bus_rd_nwr_i  (rd_nwr),
    .bus_reg_num_i (reg_num),
    .bus_bytesel_i (bytesel),
    .bus_data_i    (din),
    .bus_data_o    (dout),
    .bus_intr_o    (bus_intr),
    .red_o         (red),
    .green_o       (green),
    .blue_o        (blue),
    .hsync_o       (hsync),
    .vsync_o       (vsync),
    .dv_de_o       (de)
);

`include "tb_checks.svh"

task automatic fail_run();
    $display("*** TEST FAILED ***");
    $fatal(1, "run stopped");
endtask

// nibble n replaced only when mask bit n is set
function automatic word_t merge_nibbles(input word_t old, input word_t data,
                                        input nibble_mask_t mask);
    word_t keep;    // 1 where new data goes in
    keep = {{4{mask[3]}}, {4{mask[2]}}, {4{mask[1]}}, {4{mask[0]}}};
    return (old & ~keep) | (data & keep);
endfunction

// expected color of the n-th visible pixel of a frame
function automatic rgb_t pixel_rgb(input int n);
    int         x;
    int         y;
    word_t      w;
    color_idx_t idx;
    x   = n % H_VIS;
    y   = n / H_VIS;
    w   = vram_model[y * (H_VIS / 2) + x / 2];
    idx = (x % 2 == 0) ? w[15:8] : w[7:0];     // upper byte on even pixel
    return rgb_t'(pal_model[idx][11:0]);
endfunction

task automatic host_write(input word_t data, input nibble_mask_t mask);
    reg_write(R_WR_MASK, word_t'(mask));
    mask_model = mask;
    reg_write(R_DATA, data);
    wait_not_busy();
    vram_model[wr_addr_model] = merge_nibbles(vram_model[wr_addr_model], data, mask);
    wr_addr_model = wr_addr_model + 1'b1;      // auto increment
endtask

task automatic read_and_check(input vaddr_t a);
    word_t got;
    vram_read(a, got);
    check_word($sformatf("R_RD_DATA @%04h", a), got, vram_model[a]);
endtask

task automatic wait_vsync_rise();
    logic prev;
    logic seen;
    prev = 1'b1;                // a vsync already running does not count
    seen = 1'b0;
    while (!seen) begin
        @(posedge clk);
        #1;
        seen = vsync && !prev;
        prev = vsync;
    end
endtask

// one full frame from the vsync edge
task automatic check_frame();
    int vs_count;
    int hs_count;
    int de_count;
    vs_count = 0;
    hs_count = 0;
    de_count = 0;
    wait_vsync_rise();
    for (int c = 0; c < FRAME; c++) begin
        if (c != 0) begin
            @(posedge clk);
            #1;
        end
        if (vsync) vs_count++;
        if (hsync) hs_count++;
        if (de) begin
            check_rgb($sformatf("rgb pixel %0d", de_count), rgb_t'({red, green, blue}),
                      pixel_rgb(de_count));
            de_count++;
        end else begin
            check_rgb("rgb in blanking", rgb_t'({red, green, blue}), '0);
        end
    end
    check_word("vsync cycles", word_t'(vs_count), word_t'(V_SYNC * H_TOTAL));
    check_word("hsync cycles", word_t'(hs_count), word_t'(H_SYNC * (FRAME / H_TOTAL)));
    check_word("de cycles", word_t'(de_count), word_t'(V_VIS * H_VIS));
endtask

// host traffic while the frame is scanned, kept off the image words
task automatic live_accesses();
    vaddr_t a;
    do begin
        @(posedge clk);
        #1;
    end while (!de);
    for (int i = 0; i < N_LIVE; i++) begin
        a = vaddr_t'($urandom_range(FILL_WORDS - 1, IMG_WORDS));
        reg_write(R_WR_ADDR, a);
        wr_addr_model = a;
        host_write(word_t'($urandom), nibble_mask_t'($urandom));
        read_and_check(a);
    end
endtask

task automatic intr_test();
    intr_t sig;
    intr_t clr;
    logic  pulse;
    word_t st;
    imask_model = intr_t'($urandom) & 4'hE;    // vsync source masked off here
    reg_write(R_INTR_MASK, word_t'(imask_model));
    for (int i = 0; i < N_INTR; i++) begin
        sig   = intr_t'($urandom) & 4'hE;
        pulse = 1'b0;
        for (int n = 1; n < 4; n++) begin
            if (sig[n] && imask_model[n] && !istat_model[n]) begin
                pulse = 1'b1;   // enabled source not yet pending
            end
        end
        reg_write(R_INTR_SIGNAL, word_t'(sig));
        check_intr("bus_intr_o early", intr_t'(bus_intr), 4'h0);
        @(posedge clk);
        #1;
        check_intr("bus_intr_o", intr_t'(bus_intr), intr_t'(pulse));
        @(posedge clk);
        #1;
        check_intr("bus_intr_o after pulse", intr_t'(bus_intr), 4'h0);
        istat_model = istat_model | sig;
        clr = intr_t'($urandom) & 4'hE;
        reg_write(R_INTR_CLEAR, word_t'(clr));
        istat_model = istat_model & ~clr;
        reg_read(R_STATUS, st);
        check_intr("R_STATUS intr", st[3:0] & 4'hE, istat_model);
    end
    // source 0, pulse lines up with the vsync_o edge
    imask_model = 4'h1;
    reg_write(R_INTR_MASK, 16'h0001);
    wait_vsync_rise();
    reg_write(R_INTR_CLEAR, 16'h0001);
    wait_vsync_rise();
    check_intr("bus_intr_o at vsync", intr_t'(bus_intr), 4'h1);
    @(posedge clk);
    #1;
    check_intr("bus_intr_o after vsync", intr_t'(bus_intr), 4'h0);
    reg_read(R_STATUS, st);
    check_intr("R_STATUS intr", st[3:0], istat_model | 4'h1);
    reg_write(R_INTR_CLEAR, 16'h000F);
    istat_model = '0;
    reg_read(R_STATUS, st);
    check_word("R_STATUS", st, 16'h0000);
endtask

initial begin
    int unsigned seed_dummy;
    word_t       v;
    word_t       st;
    int          base;
    seed_dummy = $urandom(98253);
    reset_i    = 1'b1;
    cs_n       = 1'b1;
    rd_nwr     = 1'b1;
    reg_num    = R_STATUS;
    bytesel    = 1'b0;
    din        = '0;
    istat_model    = '0;
    imask_model    = '0;
    wr_addr_model  = '0;
    mask_model     = 4'hF;
    pal_addr_model = '0;
    repeat (16) @(posedge clk);
    #1;
    check_rgb("rgb in reset", rgb_t'({red, green, blue}), '0);
    check_word("syncs in reset", word_t'({hsync, vsync, de}), '0);
    check_intr("bus_intr_o in reset", intr_t'(bus_intr), 4'h0);
    reset_i = 1'b0;
    reg_read(R_STATUS, st);
    check_word("R_STATUS after reset", st, 16'h0000);
    reg_read(R_INTR_MASK, v);
    check_word("R_INTR_MASK after reset", v, 16'h0000);

    // full words first, so masked writes land on known data
    reg_write(R_WR_ADDR, 16'h0000);
    for (int i = 0; i < FILL_WORDS; i++) begin
        host_write(word_t'($urandom), 4'hF);
    end
    base = $urandom_range(FILL_WORDS - N_MASKED, 0);
    reg_write(R_WR_ADDR, word_t'(base));
    wr_addr_model = vaddr_t'(base);
    for (int i = 0; i < N_MASKED; i++) begin
        host_write(word_t'($urandom), nibble_mask_t'($urandom));
    end
    for (int i = 0; i < N_MASKED; i++) begin
        read_and_check(vaddr_t'(base + i));
    end

    reg_read(R_WR_ADDR, v);
    check_word("R_WR_ADDR", v, wr_addr_model);
    reg_read(R_WR_MASK, v);
    check_word("R_WR_MASK", v, word_t'(mask_model));
    st = word_t'($urandom) & 16'h000F;
    reg_write(R_INTR_MASK, st);
    reg_read(R_INTR_MASK, v);
    check_word("R_INTR_MASK", v, st);
    for (int r = 11; r < 16; r++) begin
        reg_read(reg_num_e'(r), v);
        check_word($sformatf("unused reg %0d", r), v, 16'h0000);
    end

    // palette from a random start, wraps through all 256 entries
    pal_addr_model = color_idx_t'($urandom);
    reg_write(R_PAL_ADDR, word_t'(pal_addr_model));
    for (int i = 0; i < 256; i++) begin
        v = word_t'($urandom);
        reg_write(R_PAL_DATA, v);
        pal_model[pal_addr_model] = v;
        pal_addr_model = pal_addr_model + 1'b1;
    end
    reg_read(R_PAL_ADDR, v);
    check_word("R_PAL_ADDR", v, word_t'(pal_addr_model));

    fork
        check_frame();
        live_accesses();
    join
    intr_test();

    $display("*** TEST PASSED ***");
    $finish;
end

// watchdog
initial begin
    #(WATCH_CYCLES * CLK_NS);
    $display("timeout: the test did not finish within %0d cycles", WATCH_CYCLES);
    fail_run();
end

endmodule

// ==== vlog.f ====
+incdir+.
xv_pkg.sv
bus_regs.sv
vram_port.sv
video_gen.sv
palette_out.sv
intr_ctrl.sv
xosera_top.sv
tb_xosera.sv

// ==== Bender.yml ====
package:
  name: xosera_lite

sources:
  - xv_pkg.sv
  - bus_regs.sv
  - vram_port.sv
  - video_gen.sv
  - palette_out.sv
  - intr_ctrl.sv
  - xosera_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_xosera.sv
